//--- soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus data width in bits.
`define SOC_DATA_WIDTH 32

// RAM of 16384 words fills the bottom 64 KiB.
`define SOC_RAM_WORDS 16384
`define SOC_RAM_ADDR_BITS 14

// Region bases and the number of low address bits inside each region.
`define SOC_RAM_BASE 32'h0000_0000
`define SOC_RAM_BITS 16
`define SOC_LED_BASE 32'h0001_0000
`define SOC_LED_BITS 2
`define SOC_TIMER_BASE 32'h0003_0000
`define SOC_TIMER_BITS 4

// Word offsets inside the timer region.
`define SOC_TIMER_LO 4'h0
`define SOC_TIMER_HI 4'h4

`endif

//--- soc_pkg.sv
`default_nettype none

`include "soc_params.svh"

package soc_pkg;

    // One bus word.
    typedef logic [`SOC_DATA_WIDTH-1:0] word_t;

    // Byte address.
    typedef logic [31:0] addr_t;

    // Bit n enables byte n of the word.
    typedef logic [`SOC_DATA_WIDTH/8-1:0] mask_t;

    // Current owner of the shared memory bus.
    typedef enum logic [1:0] {
        grant_none,
        grant_instr,
        grant_data
    } grant_t;

endpackage

`default_nettype wire

//--- mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    import soc_pkg::*;

    addr_t address;
    logic read;
    logic write;
    mask_t write_mask;
    word_t write_value;

    // One select per responder, decoded by the arbiter.
    logic ram_sel;
    logic periph_sel;

    // Each responder returns zero when it was not selected.
    word_t ram_read_value;
    word_t periph_read_value;

    modport arbiter (
        output address,
        output read,
        output write,
        output write_mask,
        output write_value,
        output ram_sel,
        output periph_sel,
        input ram_read_value,
        input periph_read_value
    );

    modport ram (
        input address,
        input write,
        input write_mask,
        input write_value,
        input ram_sel,
        output ram_read_value
    );

    modport periph (
        input address,
        input read,
        input write,
        input write_mask,
        input write_value,
        input periph_sel,
        output periph_read_value
    );

endinterface

`default_nettype wire

//--- bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module bus_arbiter (
    input logic pll_clk,
    input logic rst,

    input soc_pkg::addr_t instr_address,
    input logic instr_read,
    output soc_pkg::word_t instr_read_value,
    output logic instr_ready,

    input soc_pkg::addr_t data_address,
    input logic data_read,
    input logic data_write,
    input soc_pkg::mask_t data_write_mask,
    input soc_pkg::word_t data_write_value,
    output soc_pkg::word_t data_read_value,
    output logic data_ready,

    mem_bus_if.arbiter bus
);
    import soc_pkg::*;

    grant_t grant;
    logic last_data;
    logic instr_req;
    logic data_req;
    addr_t address;
    word_t read_value;

    // A port being answered this cycle is not pending any more.
    assign instr_req = instr_read && !instr_ready;
    assign data_req = (data_read || data_write) && !data_ready;

    // Grant cycle, then ready cycle with the bus idle.
    always_ff @(posedge pll_clk) begin
        if (rst) begin
            grant <= grant_none;
            last_data <= 1'b0;
            instr_ready <= 1'b0;
            data_ready <= 1'b0;
        end else begin
            instr_ready <= (grant == grant_instr);
            data_ready <= (grant == grant_data);
            if (grant != grant_none) begin
                grant <= grant_none;
            end else if (instr_req && (!data_req || last_data)) begin
                grant <= grant_instr;
                last_data <= 1'b0;
            end else if (data_req) begin
                grant <= grant_data;
                last_data <= 1'b1;
            end
        end
    end

    always_comb begin
        address = '0;
        bus.read = 1'b0;
        bus.write = 1'b0;
        bus.write_mask = '0;
        bus.write_value = '0;
        case (grant)
            grant_instr: begin
                address = instr_address;
                bus.read = instr_read;
            end
            grant_data: begin
                address = data_address;
                bus.read = data_read;
                bus.write = data_write;
                bus.write_mask = data_write_mask;
                bus.write_value = data_write_value;
            end
            default: begin
                address = '0;
            end
        endcase
        bus.address = address;

        // Address decode, same map as the full system.
        bus.ram_sel = (grant != grant_none) &&
            (((address ^ `SOC_RAM_BASE) >> `SOC_RAM_BITS) == '0);
        bus.periph_sel = (grant != grant_none) &&
            ((((address ^ `SOC_LED_BASE) >> `SOC_LED_BITS) == '0) ||
             (((address ^ `SOC_TIMER_BASE) >> `SOC_TIMER_BITS) == '0));
    end

    assign read_value = bus.ram_read_value | bus.periph_read_value;

    assign instr_read_value = instr_ready ? read_value : '0;
    assign data_read_value = data_ready ? read_value : '0;

endmodule

`default_nettype wire

//--- ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module ram (
    input logic pll_clk,
    mem_bus_if.ram bus
);
    import soc_pkg::*;

    word_t mem [`SOC_RAM_WORDS];
    word_t read_value;
    logic [`SOC_RAM_ADDR_BITS-1:0] index;

    // Word index, byte offset dropped.
    assign index = bus.address[`SOC_RAM_ADDR_BITS+1:2];

    always_ff @(posedge pll_clk) begin
        if (bus.ram_sel && bus.write) begin
            for (int i = 0; i < $bits(mask_t); i++) begin
                if (bus.write_mask[i]) begin
                    mem[index][i*8 +: 8] <= bus.write_value[i*8 +: 8];
                end
            end
        end
    end

    // Old contents are returned on a write cycle.
    always_ff @(posedge pll_clk) begin
        if (bus.ram_sel) begin
            read_value <= mem[index];
        end else begin
            read_value <= '0;
        end
    end

    assign bus.ram_read_value = read_value;

endmodule

`default_nettype wire

//--- periph_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module periph_regs (
    input logic pll_clk,
    input logic rst,
    output logic [7:0] leds,
    mem_bus_if.periph bus
);
    import soc_pkg::*;

    logic [63:0] timer;
    logic timer_hit;
    logic led_write;
    logic [`SOC_TIMER_BITS-1:0] offset;
    word_t reg_value;
    word_t read_value;

    // The select covers only the LED and timer regions.
    assign timer_hit = ((bus.address ^ `SOC_TIMER_BASE) >> `SOC_TIMER_BITS) == '0;
    assign offset = bus.address[`SOC_TIMER_BITS-1:0];
    assign led_write = bus.periph_sel && bus.write && !timer_hit && bus.write_mask[0];

    always_ff @(posedge pll_clk) begin
        if (rst) begin
            leds <= 8'h00;
            timer <= 64'd0;
        end else begin
            timer <= timer + 64'd1;
            if (led_write) begin
                leds <= bus.write_value[7:0];
            end
        end
    end

    always_comb begin
        reg_value = '0;
        if (!timer_hit) begin
            reg_value = word_t'(leds);
        end else if (offset == `SOC_TIMER_LO) begin
            reg_value = timer[31:0];
        end else if (offset == `SOC_TIMER_HI) begin
            reg_value = timer[63:32];
        end
    end

    // Registered to line up with the RAM output.
    always_ff @(posedge pll_clk) begin
        if (bus.periph_sel && bus.read) begin
            read_value <= reg_value;
        end else begin
            read_value <= '0;
        end
    end

    assign bus.periph_read_value = read_value;

endmodule

`default_nettype wire

//--- soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top (
    input logic pll_clk,
    input logic rst,

    input soc_pkg::addr_t instr_address,
    input logic instr_read,
    output soc_pkg::word_t instr_read_value,
    output logic instr_ready,

    input soc_pkg::addr_t data_address,
    input logic data_read,
    input logic data_write,
    input soc_pkg::mask_t data_write_mask,
    input soc_pkg::word_t data_write_value,
    output soc_pkg::word_t data_read_value,
    output logic data_ready,

    output logic [7:0] leds
);

    // Shared memory bus.
    mem_bus_if bus_if ();

    bus_arbiter u_arbiter (
        .pll_clk(pll_clk),
        .rst(rst),
        .instr_address(instr_address),
        .instr_read(instr_read),
        .instr_read_value(instr_read_value),
        .instr_ready(instr_ready),
        .data_address(data_address),
        .data_read(data_read),
        .data_write(data_write),
        .data_write_mask(data_write_mask),
        .data_write_value(data_write_value),
        .data_read_value(data_read_value),
        .data_ready(data_ready),
        .bus(bus_if.arbiter)
    );

    ram u_ram (
        .pll_clk(pll_clk),
        .bus(bus_if.ram)
    );

    // LED register and cycle timer.
    periph_regs u_periph (
        .pll_clk(pll_clk),
        .rst(rst),
        .leds(leds),
        .bus(bus_if.periph)
    );

endmodule

`default_nettype wire

//--- soc_mem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_properties (
    input logic pll_clk,
    input logic rst,
    input logic instr_read,
    input logic data_read,
    input logic data_write,
    input logic instr_ready,
    input logic data_ready,
    input soc_pkg::grant_t grant
);
    import soc_pkg::*;

    logic [2:0] instr_wait;
    logic [2:0] data_wait;

    // Cycles a request has been pending without its ready.
    always_ff @(posedge pll_clk) begin
        if (rst || !instr_read || instr_ready) begin
            instr_wait <= '0;
        end else begin
            instr_wait <= instr_wait + 3'd1;
        end
        if (rst || !(data_read || data_write) || data_ready) begin
            data_wait <= '0;
        end else begin
            data_wait <= data_wait + 3'd1;
        end
    end

    a_instr_pulse: assert property (@(posedge pll_clk) disable iff (rst)
        instr_ready |=> !instr_ready) else $error("instr_ready held two cycles");
    a_data_pulse: assert property (@(posedge pll_clk) disable iff (rst)
        data_ready |=> !data_ready) else $error("data_ready held two cycles");
    a_one_ready: assert property (@(posedge pll_clk) disable iff (rst)
        !(instr_ready && data_ready)) else $error("both readies high together");

    // A grant only goes to a port that is requesting.
    a_instr_grant: assert property (@(posedge pll_clk) disable iff (rst)
        (grant == grant_instr) |-> instr_read) else $error("instr grant without request");
    a_data_grant: assert property (@(posedge pll_clk) disable iff (rst)
        (grant == grant_data) |-> (data_read || data_write))
        else $error("data grant without request");

    a_instr_served: assert property (@(posedge pll_clk) disable iff (rst)
        (instr_wait == 3'd4) |-> instr_ready) else $error("instr request starved");
    a_data_served: assert property (@(posedge pll_clk) disable iff (rst)
        (data_wait == 3'd4) |-> data_ready) else $error("data request starved");

endmodule

`default_nettype wire

//--- tb_soc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem;
    import soc_pkg::*;

    logic pll_clk;
    logic rst;
    addr_t instr_address;
    logic instr_read;
    word_t instr_read_value;
    logic instr_ready;
    addr_t data_address;
    logic data_read;
    logic data_write;
    mask_t data_write_mask;
    word_t data_write_value;
    word_t data_read_value;
    logic data_ready;
    logic [7:0] leds;

    // One entry per stimulus line.
    logic [127:0] names [$];
    logic [7:0] ports [$];
    logic [7:0] ops [$];
    addr_t addrs [$];
    mask_t masks [$];
    word_t wvals [$];
    word_t expects [$];

    integer seed;
    int num_tests = 0;
    int errors = 0;
    int failed_tests = 0;
    int both_tests = 0;
    logic [7:0] last_port;

    soc_mem_top u_dut (.*);

    bind bus_arbiter soc_mem_properties u_props (
        .pll_clk(pll_clk),
        .rst(rst),
        .instr_read(instr_read),
        .data_read(data_read),
        .data_write(data_write),
        .instr_ready(instr_ready),
        .data_ready(data_ready),
        .grant(grant)
    );

    initial begin
        pll_clk = 1'b0;
        forever #5 pll_clk = ~pll_clk;
    end

    // Twenty cycles per stimulus line is far more than any test needs.
    initial begin
        wait (num_tests > 0);
        repeat (num_tests * 20) @(posedge pll_clk);
        $display("Watchdog expired after %0d cycles", num_tests * 20);
        $display("Regression failed");
        $finish;
    end

    // One access on one port, cycles counts from the request to its ready.
    task automatic access(input logic [7:0] port, input logic wr, input addr_t addr,
                          input mask_t mask, input word_t wdata,
                          output word_t rdata, output int cycles);
        logic done;
        done = 1'b0;
        cycles = 0;
        rdata = '0;
        @(posedge pll_clk);
        if (port == "i") begin
            instr_address <= addr;
            instr_read <= 1'b1;
        end else begin
            data_address <= addr;
            data_read <= !wr;
            data_write <= wr;
            data_write_mask <= mask;
            data_write_value <= wdata;
        end
        while (!done && cycles < 10) begin
            @(negedge pll_clk);
            if (port == "i" && instr_ready) begin
                rdata = instr_read_value;
                done = 1'b1;
            end else if (port != "i" && data_ready) begin
                rdata = data_read_value;
                done = 1'b1;
            end else begin
                cycles++;
            end
        end
        @(posedge pll_clk);
        instr_read <= 1'b0;
        data_read <= 1'b0;
        data_write <= 1'b0;
        if (!done) begin
            $display("No ready on port %s within 10 cycles", port);
            errors++;
        end
        last_port = port;
    endtask

    // Both ports read the same address at once.
    task automatic read_both(input addr_t addr, output word_t ival, output word_t dval,
                             output int icyc, output int dcyc);
        icyc = -1;
        dcyc = -1;
        ival = '0;
        dval = '0;
        @(posedge pll_clk);
        instr_address <= addr;
        instr_read <= 1'b1;
        data_address <= addr;
        data_read <= 1'b1;
        data_write <= 1'b0;
        for (int cyc = 0; cyc < 12 && (icyc < 0 || dcyc < 0); cyc++) begin
            @(negedge pll_clk);
            if (instr_ready && data_ready) begin
                $display("Both readies high in one cycle at %0t", $time);
                errors++;
            end
            if (instr_ready) begin
                ival = instr_read_value;
                icyc = cyc;
            end
            if (data_ready) begin
                dval = data_read_value;
                dcyc = cyc;
            end
            @(posedge pll_clk);
            if (icyc == cyc) instr_read <= 1'b0;
            if (dcyc == cyc) data_read <= 1'b0;
        end
        last_port = (icyc > dcyc) ? "i" : "d";
    endtask

    initial begin
        int fd;
        int n;
        int err_before;
        int c0;
        int c1;
        string line;
        logic [127:0] name;
        logic [7:0] port;
        logic [7:0] op;
        logic [7:0] prev;
        addr_t addr;
        mask_t mask;
        word_t wval;
        word_t expv;
        word_t r0;
        word_t r1;
        seed = 32'h0363_b570;
        last_port = "n";
        rst <= 1'b1;
        instr_address <= '0;
        instr_read <= 1'b0;
        data_address <= '0;
        data_read <= 1'b0;
        data_write <= 1'b0;
        data_write_mask <= '0;
        data_write_value <= '0;
        fd = $fopen("soc_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open soc_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %s %h %h %h %h",
                                name, port, op, addr, mask, wval, expv);
                    if (n == 7) begin
                        names.push_back(name);
                        ports.push_back(port);
                        ops.push_back(op);
                        addrs.push_back(addr);
                        masks.push_back(mask);
                        wvals.push_back(wval);
                        expects.push_back(expv);
                    end
                end
            end
            $fclose(fd);
        end
        num_tests = names.size();
        if (num_tests == 0) begin
            $display("No tests found in soc_stim.txt");
            errors++;
        end

        repeat (3) @(posedge pll_clk);
        rst <= 1'b0;
        @(negedge pll_clk);
        if (instr_ready !== 1'b0 || data_ready !== 1'b0 || leds !== 8'h00) begin
            $display("** Error reset: expected 000, actual %03h", {instr_ready, data_ready, leds});
            errors++;
            failed_tests++;
            $display("Test reset FAILED");
        end else begin
            $display("Test reset ok");
        end

        for (int t = 0; t < num_tests; t++) begin
            err_before = errors;
            repeat ($unsigned($random(seed)) % 4) @(posedge pll_clk);
            case (ops[t])
                "w", "r": begin
                    if (ports[t] == "b") begin
                        // Every second tie follows an instruction access.
                        if (both_tests % 2 == 1) begin
                            access("i", 1'b0, addrs[t], '0, '0, r0, c0);
                            if (r0 !== expects[t]) begin
                                $display("** Error %0s lead: expected %08h, actual %08h",
                                         names[t], expects[t], r0);
                                errors++;
                            end
                        end
                        both_tests++;
                        prev = last_port;
                        read_both(addrs[t], r0, r1, c0, c1);
                        if (r0 !== expects[t]) begin
                            $display("** Error %0s instr: expected %08h, actual %08h",
                                     names[t], expects[t], r0);
                            errors++;
                        end
                        if (r1 !== expects[t]) begin
                            $display("** Error %0s data: expected %08h, actual %08h",
                                     names[t], expects[t], r1);
                            errors++;
                        end
                        if (!((c0 == 2 && c1 == 4) || (c0 == 4 && c1 == 2))) begin
                            $display("Ready timing wrong in %0s: instr %0d, data %0d",
                                     names[t], c0, c1);
                            errors++;
                        end
                        if ((prev == "i" && c1 != 2) || (prev == "d" && c0 != 2)) begin
                            $display("Round robin order wrong in %0s", names[t]);
                            errors++;
                        end
                    end else begin
                        access(ports[t], ops[t] == "w", addrs[t], masks[t], wvals[t], r0, c0);
                        if (c0 != 2) begin
                            $display("Ready after %0d cycles in %0s", c0, names[t]);
                            errors++;
                        end
                        if (ops[t] == "r" && r0 !== expects[t]) begin
                            $display("** Error %0s: expected %08h, actual %08h",
                                     names[t], expects[t], r0);
                            errors++;
                        end
                    end
                end
                "t": begin
                    access("d", 1'b0, addrs[t], '0, '0, r0, c0);
                    access("d", 1'b0, addrs[t], '0, '0, r1, c1);
                    if (r1 <= r0) begin
                        $display("** Error %0s: expected above %08h, actual %08h",
                                 names[t], r0, r1);
                        errors++;
                    end
                end
                "x": begin
                    r1 = $random(seed);
                    access("d", 1'b1, addrs[t], 4'hf, r1, r0, c0);
                    access("d", 1'b0, addrs[t], 4'h0, '0, r0, c0);
                    if (r0 !== r1) begin
                        $display("** Error %0s: expected %08h, actual %08h", names[t], r1, r0);
                        errors++;
                    end
                end
                "l": begin
                    @(negedge pll_clk);
                    if (word_t'(leds) !== expects[t]) begin
                        $display("** Error %0s: expected %08h, actual %08h",
                                 names[t], expects[t], word_t'(leds));
                        errors++;
                    end
                end
                default: begin
                    $display("Unknown operation %s in %0s", ops[t], names[t]);
                    errors++;
                end
            endcase
            if (errors != err_before) begin
                failed_tests++;
                $display("Test %0s FAILED", names[t]);
            end else begin
                $display("Test %0s ok", names[t]);
            end
        end

        $display("Tests run %0d, failed %0d, errors %0d", num_tests + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- soc_stim.txt
# name port(i/d/b) op(w/r/t/x/l) address mask write_value expected
# op w write, r read, t timer rises, x random write and read back, l leds port
wr_full d w 00000100 f deadbeef 00000000
rd_full d r 00000100 0 00000000 deadbeef
rd_instr i r 00000100 0 00000000 deadbeef
wr_byte0 d w 00000100 1 00000011 00000000
wr_byte2 d w 00000100 4 00220000 00000000
rd_partial d r 00000100 0 00000000 de22be11
wr_base d w 00000104 f 01234567 00000000
wr_odd_bytes d w 00000104 a 55667788 00000000
rd_odd_bytes d r 00000104 0 00000000 55237767
wr_led d w 00010000 1 000000a5 00000000
chk_led d l 00010000 0 00000000 000000a5
rd_led d r 00010000 0 00000000 000000a5
wr_led_nomask d w 00010000 e 0000005a 00000000
chk_led_keep d l 00010000 0 00000000 000000a5
tmr_hi d r 00030004 0 00000000 00000000
tmr_rise d t 00030000 0 00000000 00000000
wr_unmapped d w 00020000 f ffffffff 00000000
rd_unmapped d r 00020000 0 00000000 00000000
rd_unmap_instr i r 00020004 0 00000000 00000000
rnd_ram d x 00000200 f 00000000 00000000
both_ram b r 00000100 0 00000000 de22be11
both_led b r 00010000 0 00000000 000000a5
both_ram2 b r 00000104 0 00000000 55237767

//--- flist.f
+incdir+.
soc_pkg.sv
mem_bus_if.sv
bus_arbiter.sv
ram.sv
periph_regs.sv
soc_mem_top.sv
soc_mem_properties.sv
tb_soc_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_soc_mem -o sim_soc_mem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_soc_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
